//--- Bender.yml
package:
  name: cache_wt2

sources:
  - cache_cfg_pkg.sv
  - cache_bus_pkg.sv
  - cache_tag_store.sv
  - cache_data_store.sv
  - cache_replacement.sv
  - cache_write_buffer.sv
  - cache_controller.sv
  - cache_top.sv
  - target: test
    files:
      - tb_cache_checker.sv
      - tb_cache.sv

//--- cache_bus_pkg.sv
/* front-end, write-through and refill payloads plus the controller enums
   a request with a zero strobe is a read, word 0 of a line sits in the low bits */
package cache_bus_pkg;

   // front-end request, byte address
   typedef struct packed {
      logic [cache_cfg_pkg::ADDR_W-1:0] addr;
      logic [cache_cfg_pkg::DATA_W-1:0] wdata;
      logic [cache_cfg_pkg::NBYTES-1:0] wstrb;
   } fe_req_t;

   typedef struct packed {
      logic [cache_cfg_pkg::DATA_W-1:0] rdata;
   } fe_rsp_t;

   // one buffered write, word address
   typedef struct packed {
      logic [cache_cfg_pkg::WADDR_W-1:0] waddr;
      logic [cache_cfg_pkg::DATA_W-1:0]  data;
      logic [cache_cfg_pkg::NBYTES-1:0]  strb;
   } wtbuf_entry_t;

   typedef struct packed {
      logic [cache_cfg_pkg::LINE_W-1:0] line;
   } refill_t;

   typedef enum logic {
      ACC_READ,
      ACC_WRITE
   } access_e;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_DRAIN,
      ST_REFILL,
      ST_RESPOND
   } cache_state_e;

endpackage

//--- cache_cfg_pkg.sv
/* fixed geometry of the two-way cache on a 16-bit byte address
   changing a width here changes every module, there are no module parameters */
package cache_cfg_pkg;

   // front-end word
   localparam int ADDR_W   = 16;
   localparam int DATA_W   = 32;
   localparam int NBYTES   = DATA_W / 8;
   localparam int NBYTES_W = $clog2(NBYTES);

   // line and set geometry
   localparam int WORD_OFFSET_W = 2;
   localparam int NWORDS        = 2 ** WORD_OFFSET_W;
   localparam int SET_INDEX_W   = 4;
   localparam int NSETS         = 2 ** SET_INDEX_W;
   localparam int NWAYS         = 2;
   localparam int NWAYS_W       = $clog2(NWAYS);

   // derived address splits
   localparam int TAG_W       = ADDR_W - SET_INDEX_W - WORD_OFFSET_W - NBYTES_W;
   localparam int LINE_W      = NWORDS * DATA_W;
   localparam int LINE_ADDR_W = ADDR_W - WORD_OFFSET_W - NBYTES_W;
   localparam int WADDR_W     = ADDR_W - NBYTES_W;

   // write-through buffer
   localparam int WTBUF_DEPTH_W = 2;
   localparam int WTBUF_DEPTH   = 2 ** WTBUF_DEPTH_W;

endpackage

//--- cache_controller.sv
/* one access in flight, the next req_i is ignored until ack_o
   a read miss waits for the write buffer to drain before the refill */
`timescale 1ns/1ps

module cache_controller (
   input  logic                                    clk_i,
   input  logic                                    arst_i,
   input  logic                                    req_i,
   input  cache_bus_pkg::fe_req_t                  req_data_i,
   output logic                                    ack_o,
   input  logic [cache_cfg_pkg::NWAYS-1:0]         way_hit_i,
   input  logic [cache_cfg_pkg::NWAYS_W-1:0]       way_hit_bin_i,
   input  logic [cache_cfg_pkg::NWAYS_W-1:0]       victim_i,
   input  logic                                    buf_full_i,
   input  logic                                    buf_empty_i,
   output logic                                    buf_push_o,
   output cache_bus_pkg::wtbuf_entry_t             buf_entry_o,
   output logic                                    lookup_o,
   output logic [cache_cfg_pkg::SET_INDEX_W-1:0]   index_o,
   output logic [cache_cfg_pkg::TAG_W-1:0]         tag_o,
   output logic [cache_cfg_pkg::WORD_OFFSET_W-1:0] offset_o,
   output logic [cache_cfg_pkg::NWAYS_W-1:0]       way_o,
   output logic [cache_cfg_pkg::NBYTES-1:0]        word_we_o,
   output logic [cache_cfg_pkg::DATA_W-1:0]        wdata_o,
   output logic                                    fill_o,
   output logic                                    touch_o,
   output logic                                    mem_rd_req_o,
   output logic [cache_cfg_pkg::LINE_ADDR_W-1:0]   mem_rd_addr_o,
   input  logic                                    mem_rd_valid_i
);
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;

   cache_state_e state_q, state_d;
   fe_req_t      req_q;
   access_e      acc_q;
   logic         rd_req_q;
   logic         hit;
   logic         is_write;

   assign hit      = |way_hit_i;
   assign is_write = (acc_q == ACC_WRITE);

   //////////////////////////////
   // captured request fields
   //////////////////////////////
   assign tag_o         = req_q.addr[ADDR_W-1 -: TAG_W];
   assign index_o       = req_q.addr[NBYTES_W+WORD_OFFSET_W +: SET_INDEX_W];
   assign offset_o      = req_q.addr[NBYTES_W +: WORD_OFFSET_W];
   assign wdata_o       = req_q.wdata;
   assign mem_rd_addr_o = req_q.addr[ADDR_W-1 -: LINE_ADDR_W];
   assign mem_rd_req_o  = rd_req_q;
   assign buf_entry_o   = '{waddr: req_q.addr[ADDR_W-1:NBYTES_W],
                            data:  req_q.wdata,
                            strb:  req_q.wstrb};

   // victim during refill, else the hitting way
   assign way_o = (state_q == ST_REFILL) ? victim_i : way_hit_bin_i;

   always_ff @(posedge clk_i) begin
      if (state_q == ST_IDLE && req_i) begin
         req_q <= req_data_i;
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q  <= ST_IDLE;
         acc_q    <= ACC_READ;
         rd_req_q <= 1'b0;
      end else begin
         state_q  <= state_d;
         rd_req_q <= (state_q == ST_DRAIN) && buf_empty_i;
         if (state_q == ST_IDLE && req_i) begin
            acc_q <= (|req_data_i.wstrb) ? ACC_WRITE : ACC_READ;
         end
      end
   end

   //////////////////////////////
   // access FSM
   //////////////////////////////
   always_comb begin
      state_d    = state_q;
      lookup_o   = 1'b0;
      ack_o      = 1'b0;
      buf_push_o = 1'b0;
      word_we_o  = '0;
      touch_o    = 1'b0;
      fill_o     = 1'b0;
      case (state_q)
         ST_IDLE: begin
            if (req_i) begin
               state_d = ST_LOOKUP;
            end
         end
         ST_LOOKUP: begin
            lookup_o = 1'b1;
            // a write holds here until the buffer has room
            if (!(is_write && buf_full_i)) begin
               state_d = ST_RESPOND;
            end
         end
         ST_RESPOND: begin
            if (is_write) begin
               // no allocate on a write miss
               ack_o      = 1'b1;
               buf_push_o = 1'b1;
               touch_o    = hit;
               word_we_o  = hit ? req_q.wstrb : '0;
               state_d    = ST_IDLE;
            end else if (hit) begin
               ack_o   = 1'b1;
               touch_o = 1'b1;
               state_d = ST_IDLE;
            end else begin
               state_d = ST_DRAIN;
            end
         end
         ST_DRAIN: begin
            if (buf_empty_i) begin
               state_d = ST_REFILL;
            end
         end
         ST_REFILL: begin
            fill_o = mem_rd_valid_i;
            // look up again, the read is then a hit
            if (mem_rd_valid_i) begin
               state_d = ST_LOOKUP;
            end
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   // memory must already hold every earlier write when the refill starts
   a_refill_after_drain: assert property (@(posedge clk_i) disable iff (arst_i)
      mem_rd_req_o |-> buf_empty_i)
      else $error("controller: refill requested with writes pending");

endmodule

//--- cache_data_store.sv
/* line storage per way, no reset, contents are unknown until filled
   a fill takes priority over a word write in the same cycle */
`timescale 1ns/1ps

module cache_data_store (
   input  logic                                   clk_i,
   input  logic                                   lookup_i,
   input  logic [cache_cfg_pkg::SET_INDEX_W-1:0]  index_i,
   input  logic [cache_cfg_pkg::WORD_OFFSET_W-1:0] offset_i,
   input  logic [cache_cfg_pkg::NWAYS_W-1:0]      way_i,
   input  logic [cache_cfg_pkg::NBYTES-1:0]       word_we_i,
   input  logic [cache_cfg_pkg::DATA_W-1:0]       wdata_i,
   input  logic                                   fill_i,
   input  cache_bus_pkg::refill_t                 fill_line_i,
   output cache_bus_pkg::fe_rsp_t                 rdata_o
);
   import cache_cfg_pkg::*;

   logic [NWORDS-1:0][DATA_W-1:0] line_mem [NWAYS][NSETS];
   logic [NWORDS-1:0][DATA_W-1:0] line_rd_q [NWAYS];

   //////////////////////////////
   // writes
   //////////////////////////////
   always_ff @(posedge clk_i) begin
      if (fill_i) begin
         line_mem[way_i][index_i] <= fill_line_i.line;
      end else begin
         // byte lanes of one word
         for (int b = 0; b < NBYTES; b++) begin
            if (word_we_i[b]) begin
               line_mem[way_i][index_i][offset_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
      end
   end

   //////////////////////////////
   // registered read
   //////////////////////////////
   // both ways are read, the way is picked after the compare
   always_ff @(posedge clk_i) begin
      if (lookup_i) begin
         for (int w = 0; w < NWAYS; w++) begin
            line_rd_q[w] <= line_mem[w][index_i];
         end
      end
   end

   assign rdata_o = line_rd_q[way_i][offset_i];

endmodule

//--- cache_replacement.sv
/* one LRU bit per set, valid for exactly two ways */
`timescale 1ns/1ps

module cache_replacement (
   input  logic                                  clk_i,
   input  logic                                  arst_i,
   input  logic                                  invalidate_i,
   input  logic                                  touch_i,
   input  logic [cache_cfg_pkg::SET_INDEX_W-1:0] index_i,
   input  logic [cache_cfg_pkg::NWAYS_W-1:0]     touch_way_i,
   output logic [cache_cfg_pkg::NWAYS_W-1:0]     victim_o
);
   import cache_cfg_pkg::*;

   // way not used most recently, per set
   logic [NSETS-1:0][NWAYS_W-1:0] lru_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         lru_q <= '0;
      end else if (invalidate_i) begin
         lru_q <= '0;
      end else if (touch_i) begin
         lru_q[index_i] <= ~touch_way_i;
      end
   end

   assign victim_o = lru_q[index_i];

endmodule

//--- cache_tag_store.sv
/* tags and valid bits per way, result registered one cycle after lookup_i
   tag_i must stay stable while way_hit_o is in use */
`timescale 1ns/1ps

module cache_tag_store (
   input  logic                                clk_i,
   input  logic                                arst_i,
   input  logic                                invalidate_i,
   input  logic                                lookup_i,
   input  logic [cache_cfg_pkg::SET_INDEX_W-1:0] index_i,
   input  logic [cache_cfg_pkg::TAG_W-1:0]     tag_i,
   input  logic                                fill_i,
   input  logic [cache_cfg_pkg::NWAYS_W-1:0]   fill_way_i,
   output logic [cache_cfg_pkg::NWAYS-1:0]     way_hit_o,
   output logic [cache_cfg_pkg::NWAYS_W-1:0]   way_hit_bin_o
);
   import cache_cfg_pkg::*;

   logic [NWAYS-1:0][NSETS-1:0] valid_q;
   logic [TAG_W-1:0]            tag_mem [NWAYS][NSETS];
   logic [NWAYS-1:0]            valid_rd_q;
   logic [TAG_W-1:0]            tag_rd_q [NWAYS];

   //////////////////////////////
   // storage
   //////////////////////////////
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         valid_q <= '0;
      end else if (invalidate_i) begin
         valid_q <= '0;
      end else if (fill_i) begin
         valid_q[fill_way_i][index_i] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_i) begin
         tag_mem[fill_way_i][index_i] <= tag_i;
      end
   end

   //////////////////////////////
   // lookup and compare
   //////////////////////////////
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         valid_rd_q <= '0;
      end else if (lookup_i) begin
         for (int w = 0; w < NWAYS; w++) begin
            valid_rd_q[w] <= valid_q[w][index_i];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (lookup_i) begin
         for (int w = 0; w < NWAYS; w++) begin
            tag_rd_q[w] <= tag_mem[w][index_i];
         end
      end
   end

   // one-hot hit plus its binary way number
   always_comb begin
      way_hit_bin_o = '0;
      for (int w = 0; w < NWAYS; w++) begin
         way_hit_o[w] = valid_rd_q[w] && (tag_rd_q[w] == tag_i);
         if (way_hit_o[w]) begin
            way_hit_bin_o = NWAYS_W'(w);
         end
      end
   end

   // fills happen only after a miss, so a tag never lives in two ways of a set
   a_hit_onehot: assert property (@(posedge clk_i) disable iff (arst_i)
      $onehot0(way_hit_o))
      else $error("tag store: way_hit_o %b is not one-hot", way_hit_o);

endmodule

//--- cache_top.sv
/* two-way write-through cache, no allocate on write
   invalidate_i is legal only while no access is in progress */
`timescale 1ns/1ps

module cache_top (
   input  logic                                  clk_i,
   input  logic                                  arst_i,
   input  logic                                  invalidate_i,
   input  logic                                  req_i,
   input  cache_bus_pkg::fe_req_t                req_data_i,
   output logic                                  ack_o,
   output cache_bus_pkg::fe_rsp_t                rsp_o,
   output logic                                  mem_rd_req_o,
   output logic [cache_cfg_pkg::LINE_ADDR_W-1:0] mem_rd_addr_o,
   input  logic                                  mem_rd_valid_i,
   input  cache_bus_pkg::refill_t                mem_rd_line_i,
   output logic                                  mem_wr_req_o,
   output cache_bus_pkg::wtbuf_entry_t           mem_wr_o,
   input  logic                                  mem_wr_ack_i
);
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;

   logic                     lookup;
   logic [SET_INDEX_W-1:0]   index;
   logic [TAG_W-1:0]         tag;
   logic [WORD_OFFSET_W-1:0] offset;
   logic [NWAYS_W-1:0]       way;
   logic [NBYTES-1:0]        word_we;
   logic [DATA_W-1:0]        wdata;
   logic                     fill;
   logic                     touch;
   logic [NWAYS-1:0]         way_hit;
   logic [NWAYS_W-1:0]       way_hit_bin;
   logic [NWAYS_W-1:0]       victim;
   logic                     buf_full;
   logic                     buf_empty;
   logic                     buf_push;
   wtbuf_entry_t             buf_entry;

   cache_controller u_ctrl (
      .clk_i, .arst_i, .req_i, .req_data_i, .ack_o,
      .way_hit_i(way_hit), .way_hit_bin_i(way_hit_bin), .victim_i(victim),
      .buf_full_i(buf_full), .buf_empty_i(buf_empty),
      .buf_push_o(buf_push), .buf_entry_o(buf_entry),
      .lookup_o(lookup), .index_o(index), .tag_o(tag), .offset_o(offset),
      .way_o(way), .word_we_o(word_we), .wdata_o(wdata),
      .fill_o(fill), .touch_o(touch),
      .mem_rd_req_o, .mem_rd_addr_o, .mem_rd_valid_i
   );

   cache_tag_store u_tags (
      .clk_i, .arst_i, .invalidate_i, .lookup_i(lookup), .index_i(index), .tag_i(tag),
      .fill_i(fill), .fill_way_i(way), .way_hit_o(way_hit), .way_hit_bin_o(way_hit_bin)
   );

   cache_data_store u_data (
      .clk_i, .lookup_i(lookup), .index_i(index), .offset_i(offset), .way_i(way),
      .word_we_i(word_we), .wdata_i(wdata), .fill_i(fill), .fill_line_i(mem_rd_line_i),
      .rdata_o(rsp_o)
   );

   cache_replacement u_lru (
      .clk_i, .arst_i, .invalidate_i, .touch_i(touch), .index_i(index),
      .touch_way_i(way), .victim_o(victim)
   );

   cache_write_buffer u_wtbuf (
      .clk_i, .arst_i, .push_i(buf_push), .entry_i(buf_entry),
      .full_o(buf_full), .empty_o(buf_empty),
      .mem_wr_req_o, .mem_wr_o, .mem_wr_ack_i
   );

endmodule

//--- cache_write_buffer.sv
/* in-order write-through FIFO, one back-end write outstanding at a time
   the head entry is kept until mem_wr_ack_i, so it still counts toward full_o */
`timescale 1ns/1ps

module cache_write_buffer (
   input  logic                        clk_i,
   input  logic                        arst_i,
   input  logic                        push_i,
   input  cache_bus_pkg::wtbuf_entry_t entry_i,
   output logic                        full_o,
   output logic                        empty_o,
   output logic                        mem_wr_req_o,
   output cache_bus_pkg::wtbuf_entry_t mem_wr_o,
   input  logic                        mem_wr_ack_i
);
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;

   wtbuf_entry_t           fifo_mem [WTBUF_DEPTH];
   logic [WTBUF_DEPTH_W:0] wr_ptr_q;
   logic [WTBUF_DEPTH_W:0] rd_ptr_q;
   logic                   busy_q;
   logic                   fifo_empty;

   // extra pointer bit tells full from empty
   assign fifo_empty = (wr_ptr_q == rd_ptr_q);
   assign full_o     = (wr_ptr_q[WTBUF_DEPTH_W-1:0] == rd_ptr_q[WTBUF_DEPTH_W-1:0]) &&
                       (wr_ptr_q[WTBUF_DEPTH_W] != rd_ptr_q[WTBUF_DEPTH_W]);
   assign empty_o    = fifo_empty && !busy_q;

   // head goes out once, then waits for its ack
   assign mem_wr_req_o = !fifo_empty && !busy_q;
   assign mem_wr_o     = fifo_mem[rd_ptr_q[WTBUF_DEPTH_W-1:0]];

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         fifo_mem[wr_ptr_q[WTBUF_DEPTH_W-1:0]] <= entry_i;
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         busy_q   <= 1'b0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (mem_wr_ack_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
            busy_q   <= 1'b0;
         end else if (mem_wr_req_o) begin
            busy_q <= 1'b1;
         end
      end
   end

   // the controller checks full before it pushes
   a_no_push_full: assert property (@(posedge clk_i) disable iff (arst_i)
      push_i |-> !full_o)
      else $error("write buffer: push while full");

   // back end acks only a write that was issued
   a_ack_busy: assert property (@(posedge clk_i) disable iff (arst_i)
      mem_wr_ack_i |-> busy_q)
      else $error("write buffer: ack with no write outstanding");

endmodule

//--- sources.f
cache_cfg_pkg.sv
cache_bus_pkg.sv
cache_tag_store.sv
cache_data_store.sv
cache_replacement.sv
cache_write_buffer.sv
cache_controller.sv
cache_top.sv
tb_cache_checker.sv
tb_cache.sv

//--- tb_cache.sv
/* testbench for cache_top, back end answers after 1 to 6 cycles
   every address used is word aligned, random data from a fixed seed */
`timescale 1ns/1ps

module tb_cache;
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;

   localparam int N_RANDOM       = 60;
   localparam int N_BURST        = 12;
   localparam int N_ACCESS       = 2 + N_RANDOM + 5 + 8 + N_BURST + 4;
   localparam int TIMEOUT_CYCLES = 200 * N_ACCESS + 1000;

   logic                   clk_i;
   logic                   arst_i;
   logic                   invalidate_i;
   logic                   req_i;
   fe_req_t                req_data_i;
   logic                   ack_o;
   fe_rsp_t                rsp_o;
   logic                   mem_rd_req_o;
   logic [LINE_ADDR_W-1:0] mem_rd_addr_o;
   logic                   mem_rd_valid_i;
   refill_t                mem_rd_line_i;
   logic                   mem_wr_req_o;
   wtbuf_entry_t           mem_wr_o;
   logic                   mem_wr_ack_i;

   logic [DATA_W-1:0] exp_rdata;
   logic              exp_refill;
   int unsigned       err_cnt;
   int unsigned       read_cnt;
   int unsigned       write_cnt;
   int unsigned       refill_cnt;
   int unsigned       wr_pending;

   // back-end memory and the front-end view of it
   logic [7:0] mem    [2**ADDR_W];
   logic [7:0] shadow [2**ADDR_W];

   // tag and LRU model, predicts which accesses refill
   logic             mdl_valid [NWAYS][NSETS];
   logic [TAG_W-1:0] mdl_tag   [NWAYS][NSETS];
   int               mdl_lru   [NSETS];

   cache_top UUT (.*);

   tb_cache_checker u_checker (
      .clk_i, .arst_i, .req_i, .req_data_i,
      .ack_i(ack_o), .rsp_i(rsp_o),
      .mem_rd_req_i(mem_rd_req_o), .mem_rd_addr_i(mem_rd_addr_o),
      .mem_wr_req_i(mem_wr_req_o), .mem_wr_i(mem_wr_o), .mem_wr_ack_i,
      .exp_rdata_i(exp_rdata), .exp_refill_i(exp_refill),
      .err_cnt_o(err_cnt), .read_cnt_o(read_cnt), .write_cnt_o(write_cnt),
      .refill_cnt_o(refill_cnt), .wr_pending_o(wr_pending)
   );

   //////////////////////////////
   // reference
   //////////////////////////////
   function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
      return (a[7:0] * 8'd13) ^ a[15:8] ^ 8'h5a;
   endfunction

   function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] addr);
      logic [ADDR_W-1:0] base;
      logic [DATA_W-1:0] word;
      base = {addr[ADDR_W-1:NBYTES_W], {NBYTES_W{1'b0}}};
      for (int b = 0; b < NBYTES; b++) begin
         word[8*b +: 8] = shadow[base + b];
      end
      return word;
   endfunction

   function automatic void shadow_write(input fe_req_t req);
      logic [ADDR_W-1:0] base;
      base = {req.addr[ADDR_W-1:NBYTES_W], {NBYTES_W{1'b0}}};
      for (int b = 0; b < NBYTES; b++) begin
         if (req.wstrb[b]) begin
            shadow[base + b] = req.wdata[8*b +: 8];
         end
      end
   endfunction

   function automatic void model_clear();
      for (int s = 0; s < NSETS; s++) begin
         mdl_valid[0][s] = 1'b0;
         mdl_valid[1][s] = 1'b0;
         mdl_lru[s]      = 0;
      end
   endfunction

   // write misses do not allocate, a read miss fills the LRU way
   function automatic logic predict_refill(input fe_req_t req);
      logic [SET_INDEX_W-1:0] idx;
      logic [TAG_W-1:0]       tag;
      int                     way;
      idx = req.addr[NBYTES_W+WORD_OFFSET_W +: SET_INDEX_W];
      tag = req.addr[ADDR_W-1 -: TAG_W];
      way = -1;
      for (int w = 0; w < NWAYS; w++) begin
         if (mdl_valid[w][idx] && mdl_tag[w][idx] == tag) begin
            way = w;
         end
      end
      if (way >= 0) begin
         mdl_lru[idx] = 1 - way;
         return 1'b0;
      end
      if (req.wstrb != '0) begin
         return 1'b0;
      end
      way = mdl_lru[idx];
      mdl_valid[way][idx] = 1'b1;
      mdl_tag[way][idx]   = tag;
      mdl_lru[idx]        = 1 - way;
      return 1'b1;
   endfunction

   //////////////////////////////
   // stimulus helpers
   //////////////////////////////
   // tags 0 to 2 only, so hits, misses and evictions all occur
   function automatic logic [ADDR_W-1:0] rand_addr();
      return ADDR_W'($urandom_range(0, 191)) << NBYTES_W;
   endfunction

   function automatic fe_req_t make_read(input logic [ADDR_W-1:0] addr);
      fe_req_t req;
      req.addr  = addr;
      req.wdata = '0;
      req.wstrb = '0;
      return req;
   endfunction

   function automatic fe_req_t make_write(input logic [ADDR_W-1:0] addr);
      fe_req_t req;
      req.addr  = addr;
      req.wdata = $urandom();
      req.wstrb = NBYTES'($urandom_range(1, 2**NBYTES - 1));
      return req;
   endfunction

   task automatic run_access(input fe_req_t req);
      @(negedge clk_i);
      exp_rdata  = ref_read(req.addr);
      exp_refill = predict_refill(req);
      req_data_i = req;
      req_i      = 1'b1;
      @(negedge clk_i);
      req_i = 1'b0;
      do begin
         @(posedge clk_i);
      end while (!ack_o);
      if (req.wstrb != '0) begin
         shadow_write(req);
      end
   endtask

   task automatic run_invalidate();
      @(negedge clk_i);
      invalidate_i = 1'b1;
      @(negedge clk_i);
      invalidate_i = 1'b0;
      model_clear();
   endtask

   //////////////////////////////
   // clock, back end, watchdog
   //////////////////////////////
   initial begin : clock_gen
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   initial begin : backend_model
      int unsigned            rd_wait;
      int unsigned            wr_wait;
      logic [LINE_ADDR_W-1:0] rd_line;
      wtbuf_entry_t           wr_entry;
      logic [ADDR_W-1:0]      base;
      rd_wait        = 0;
      wr_wait        = 0;
      mem_rd_valid_i = 1'b0;
      mem_rd_line_i  = '0;
      mem_wr_ack_i   = 1'b0;
      forever begin
         @(posedge clk_i);
         if (mem_rd_req_o) begin
            rd_line = mem_rd_addr_o;
            rd_wait = $urandom_range(1, 6);
         end
         if (mem_wr_req_o) begin
            wr_entry = mem_wr_o;
            wr_wait  = $urandom_range(1, 6);
         end
         @(negedge clk_i);
         mem_rd_valid_i = 1'b0;
         mem_wr_ack_i   = 1'b0;
         if (rd_wait != 0) begin
            rd_wait--;
            if (rd_wait == 0) begin
               base = {rd_line, {(WORD_OFFSET_W + NBYTES_W){1'b0}}};
               for (int k = 0; k < LINE_W / 8; k++) begin
                  mem_rd_line_i.line[8*k +: 8] = mem[base + k];
               end
               mem_rd_valid_i = 1'b1;
            end
         end
         if (wr_wait != 0) begin
            wr_wait--;
            if (wr_wait == 0) begin
               base = {wr_entry.waddr, {NBYTES_W{1'b0}}};
               for (int b = 0; b < NBYTES; b++) begin
                  if (wr_entry.strb[b]) begin
                     mem[base + b] = wr_entry.data[8*b +: 8];
                  end
               end
               mem_wr_ack_i = 1'b1;
            end
         end
      end
   end

   initial begin : watchdog
      int unsigned cycles;
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $finish;
   end

   //////////////////////////////
   // test sequence
   //////////////////////////////
   initial begin : stimulus
      int unsigned       seed;
      logic [ADDR_W-1:0] burst_addr [N_BURST];
      seed         = $urandom(22106);
      arst_i       = 1'b1;
      invalidate_i = 1'b0;
      req_i        = 1'b0;
      req_data_i   = '0;
      exp_rdata    = '0;
      exp_refill   = 1'b0;
      for (int a = 0; a < 2**ADDR_W; a++) begin
         mem[a]    = fill_byte(ADDR_W'(a));
         shadow[a] = fill_byte(ADDR_W'(a));
      end
      model_clear();
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      arst_i = 1'b0;

      // miss then hit on one word
      run_access(make_read(16'h1238));
      run_access(make_read(16'h1238));

      repeat (N_RANDOM) begin
         if ($urandom_range(0, 1) != 0) begin
            run_access(make_write(rand_addr()));
         end else begin
            run_access(make_read(rand_addr()));
         end
      end

      // set 9 with tags A, B, C: C evicts B, so the last B misses
      run_invalidate();
      run_access(make_read(16'h8090));
      run_access(make_read(16'h8190));
      run_access(make_read(16'h8090));
      run_access(make_read(16'h8290));
      run_access(make_read(16'h8190));

      for (int i = 0; i < 4; i++) begin
         run_access(make_read(ADDR_W'(i) * 16'h0044));
      end
      run_invalidate();
      for (int i = 0; i < 4; i++) begin
         run_access(make_read(ADDR_W'(i) * 16'h0044));
      end

      // back-to-back writes outrun the back end and fill the buffer
      for (int i = 0; i < N_BURST; i++) begin
         burst_addr[i] = rand_addr();
         run_access(make_write(burst_addr[i]));
      end
      for (int i = 0; i < 4; i++) begin
         run_access(make_read(burst_addr[3*i]));
      end

      @(negedge clk_i);
      wait (wr_pending == 0);
      repeat (4) @(negedge clk_i);
      $display("errors %0d, reads %0d, writes %0d, refills %0d", err_cnt, read_cnt,
               write_cnt, refill_cnt);
      if (err_cnt == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- tb_cache_checker.sv
/* compares the cache ports against the testbench reference
   exp_rdata_i and exp_refill_i must stay stable from req_i until ack_o */
`timescale 1ns/1ps

module tb_cache_checker (
   input  logic                                  clk_i,
   input  logic                                  arst_i,
   input  logic                                  req_i,
   input  cache_bus_pkg::fe_req_t                req_data_i,
   input  logic                                  ack_i,
   input  cache_bus_pkg::fe_rsp_t                rsp_i,
   input  logic                                  mem_rd_req_i,
   input  logic [cache_cfg_pkg::LINE_ADDR_W-1:0] mem_rd_addr_i,
   input  logic                                  mem_wr_req_i,
   input  cache_bus_pkg::wtbuf_entry_t           mem_wr_i,
   input  logic                                  mem_wr_ack_i,
   input  logic [cache_cfg_pkg::DATA_W-1:0]      exp_rdata_i,
   input  logic                                  exp_refill_i,
   output int unsigned                           err_cnt_o,
   output int unsigned                           read_cnt_o,
   output int unsigned                           write_cnt_o,
   output int unsigned                           refill_cnt_o,
   output int unsigned                           wr_pending_o
);
   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;

   // writes acked on the front end, not yet seen on the back end
   wtbuf_entry_t exp_wr_q [$];
   fe_req_t      req_q;
   logic         in_flight;
   logic         wr_busy;
   int unsigned  latency;
   int unsigned  refills;

   task automatic report_mismatch(input string sig, input logic [DATA_W-1:0] exp_val,
                                  input logic [DATA_W-1:0] got_val);
      $display("** Error %s: expected 0x%h, got 0x%h at time %0t", sig, exp_val, got_val,
               $time);
      err_cnt_o++;
   endtask

   task automatic report_failure(input string what);
      $display("failure at time %0t: %s", $time, what);
      err_cnt_o++;
   endtask

   always @(posedge clk_i) begin
      wtbuf_entry_t           exp_e;
      logic [LINE_ADDR_W-1:0] exp_line;
      if (arst_i) begin
         exp_wr_q.delete();
         in_flight    = 1'b0;
         wr_busy      = 1'b0;
         latency      = 0;
         refills      = 0;
         err_cnt_o    = 0;
         read_cnt_o   = 0;
         write_cnt_o  = 0;
         refill_cnt_o = 0;
         wr_pending_o = 0;
      end else begin
         //////////////////////////////
         // back-end read
         //////////////////////////////
         if (mem_rd_req_i) begin
            refill_cnt_o++;
            refills++;
            if (!in_flight) begin
               report_failure("mem_rd_req_o pulsed outside an access");
            end
            if (exp_wr_q.size() != 0 || wr_busy) begin
               report_failure("mem_rd_req_o pulsed while back-end writes are outstanding");
            end
            // line address is the byte address over the line size in bytes
            exp_line = LINE_ADDR_W'(req_q.addr >> (WORD_OFFSET_W + NBYTES_W));
            if (mem_rd_addr_i !== exp_line) begin
               report_mismatch("mem_rd_addr_o", exp_line, mem_rd_addr_i);
            end
         end

         //////////////////////////////
         // back-end write
         //////////////////////////////
         if (mem_wr_ack_i) begin
            wr_busy = 1'b0;
         end
         if (mem_wr_req_i) begin
            if (exp_wr_q.size() == 0) begin
               report_failure("mem_wr_req_o pulsed with no front-end write pending");
            end else begin
               exp_e = exp_wr_q.pop_front();
               if (mem_wr_i.waddr !== exp_e.waddr) begin
                  report_mismatch("mem_wr_o.waddr", exp_e.waddr, mem_wr_i.waddr);
               end
               if (mem_wr_i.data !== exp_e.data) begin
                  report_mismatch("mem_wr_o.data", exp_e.data, mem_wr_i.data);
               end
               if (mem_wr_i.strb !== exp_e.strb) begin
                  report_mismatch("mem_wr_o.strb", exp_e.strb, mem_wr_i.strb);
               end
            end
            wr_busy = 1'b1;
         end

         //////////////////////////////
         // front end
         //////////////////////////////
         if (in_flight) begin
            latency++;
         end
         if (ack_i) begin
            if (!in_flight) begin
               report_failure("ack_o pulsed with no request pending");
            end else begin
               if (req_q.wstrb == '0) begin
                  read_cnt_o++;
                  if (rsp_i.rdata !== exp_rdata_i) begin
                     report_mismatch("rsp_o", exp_rdata_i, rsp_i.rdata);
                  end
                  // hit latency is fixed, counted from the edge that took req_i
                  if (!exp_refill_i && latency != 2) begin
                     report_failure($sformatf("read hit acknowledged after %0d cycles, not 2",
                                              latency));
                  end
               end else begin
                  write_cnt_o++;
                  // word address is the byte address over the word size in bytes
                  exp_e.waddr = WADDR_W'(req_q.addr >> NBYTES_W);
                  exp_e.data  = req_q.wdata;
                  exp_e.strb  = req_q.wstrb;
                  exp_wr_q.push_back(exp_e);
               end
               if (refills != int'(exp_refill_i)) begin
                  report_mismatch("mem_rd_req_o count", exp_refill_i, refills);
               end
            end
            in_flight = 1'b0;
         end
         if (req_i) begin
            in_flight = 1'b1;
            latency   = 0;
            refills   = 0;
            req_q     = req_data_i;
         end
         wr_pending_o = exp_wr_q.size() + int'(wr_busy);
      end
   end

endmodule
